/* tb.f */
ad7794_pkg.sv
axil_pkg.sv
spi_master.sv
ad7794.sv
ad7794_regs.sv
ad7794_top.sv
tb_adc_model.sv
tb_ad7794.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module tb_ad7794 -f tb.f -o tb_sim \
	&& ./obj_dir/tb_sim | tee sim.log \
	|| { echo "build or run failed"; exit 1; }
# the run passes only if the pass line is in the log
grep -qx "Everything OK" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* tb_ad7794.sv */
`timescale 1ns/1ns
module tb_ad7794;
	import ad7794_pkg::*;
	import axil_pkg::*;

	localparam int tsckhalf = 2;
	localparam int num_addr = 40;
	localparam int num_ops = 5 * num_addr + 20;   // bus operations, frames included.
	localparam int timeout_cycles = num_ops * (66 * tsckhalf + 40);

	logic        clkin, arst_n;
	axil_aw_t    aw;
	axil_w_t     w;
	axil_b_t     b;
	axil_ar_t    ar;
	axil_r_t     r;
	logic        awready, wready, arready, bready, rready;
	logic        sdio_as_sdo, adc_clk, cs, sclk, din, dout_rdy, adcclk;
	logic        sclk_in, mosi_in, ss_in, miso_out, spi_ssb_in, spi_ssb_out;
	logic [31:0] lfsr;
	logic [23:0] ref_regs [logic [7:0]];    // expected converter registers.
	logic [7:0]  addrs [num_addr];
	int          value_errs, other_errs;
	int          sclk_falls;                // falling sclk edges since cs fell.
	logic        sclk_prev;
	logic        frame_rd;                  // the frame in flight is a read.

	ad7794_top #(.TSCKHALF(tsckhalf), .SPIMODE("chain")) uut (
		.clkin(clkin), .arst_n(arst_n),
		.aw(aw), .awready(awready), .w(w), .wready(wready), .b(b), .bready(bready),
		.ar(ar), .arready(arready), .r(r), .rready(rready),
		.sdio_as_sdo(sdio_as_sdo), .adc_clk(adc_clk), .cs(cs), .sclk(sclk), .din(din),
		.dout_rdy(dout_rdy), .adcclk(adcclk), .sclk_in(sclk_in), .mosi_in(mosi_in),
		.ss_in(ss_in), .miso_out(miso_out), .spi_ssb_in(spi_ssb_in),
		.spi_ssb_out(spi_ssb_out)
	);

	tb_adc_model adc_model (.cs(cs), .sclk(sclk), .din(din), .dout_rdy(dout_rdy));

	always #4 clkin = ~clkin;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// random bits and compares
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic next_bit();
		lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};   // x^32+x^22+x^2+x+1.
		return lfsr[0];
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], next_bit()};
		return v;
	endfunction

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			value_errs++;
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp) begin
			value_errs++;
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	task automatic check_rsp(input string name, input spi_rsp_t exp, input spi_rsp_t act);
		if (act !== exp) begin
			value_errs++;
			$display("Error at %0t ns: %s expected %h/%h, got %h/%h", $time, name,
				exp.addr, exp.data, act.addr, act.data);
		end
	endtask

	task automatic compare_pin(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			value_errs++;
			$display("Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bus transactions
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic axil_write(input logic [3:0] addr, input logic [31:0] data,
			output logic [1:0] resp);
		logic got;
		@(posedge clkin);
		aw <= '{addr: addr, valid: 1'b1};
		w <= '{data: data, valid: 1'b1};
		@(negedge clkin);
		while (!awready && !wready)
			@(negedge clkin);
		compare_pin("awready", 1'b1, awready);   // both channels taken together.
		compare_pin("wready", 1'b1, wready);
		@(posedge clkin);             // address and data taken here.
		aw.valid <= 1'b0;
		w.valid <= 1'b0;
		got = 1'b0;
		while (!got) begin
			bready <= next_bit();     // random stall.
			@(negedge clkin);
			got = b.valid & bready;
			if (!got)
				@(posedge clkin);
		end
		resp = b.resp;
		@(posedge clkin);
		bready <= 1'b0;
		@(negedge clkin);
		if (b.valid) begin
			other_errs++;
			$display("%0t ns: write response still valid after it was accepted", $time);
		end
	endtask

	task automatic axil_read(input logic [3:0] addr, output logic [31:0] data,
			output logic [1:0] resp);
		logic got;
		@(posedge clkin);
		ar <= '{addr: addr, valid: 1'b1};
		@(negedge clkin);
		while (!arready)
			@(negedge clkin);
		@(posedge clkin);
		ar.valid <= 1'b0;
		got = 1'b0;
		while (!got) begin
			rready <= next_bit();
			@(negedge clkin);
			got = r.valid & rready;
			if (!got)
				@(posedge clkin);
		end
		data = r.data;
		resp = r.resp;
		@(posedge clkin);
		rready <= 1'b0;
		@(negedge clkin);
		if (r.valid) begin
			other_errs++;
			$display("%0t ns: read response still valid after it was accepted", $time);
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frames through the converter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic start_frame(input logic [7:0] addr, input logic rd, input logic [23:0] data);
		logic [1:0]  resp;
		logic [31:0] word;
		frame_rd = rd;
		if (!rd) begin
			axil_write(reg_wdata, {8'h00, data}, resp);
			check_resp("b.resp wdata", resp_okay, resp);
		end
		axil_write(reg_cmd, {23'h0, rd, addr}, resp);
		check_resp("b.resp cmd", resp_okay, resp);
		axil_read(reg_status, word, resp);
		check_word("status while busy", 32'h1, word);   // busy, done clear.
	endtask

	task automatic finish_frame(output logic [31:0] rdata);
		logic [1:0]  resp;
		logic [31:0] status;
		int          polls;
		polls = 0;
		status = '0;
		while (!status[1] && polls < 200) begin
			axil_read(reg_status, status, resp);
			polls++;
		end
		if (!status[1]) begin
			other_errs++;
			$display("%0t ns: done never came up after a frame", $time);
		end
		check_word("status after frame", 32'h2, status);
		axil_read(reg_rdata, rdata, resp);
		check_resp("r.resp rdata", resp_okay, resp);
		axil_read(reg_status, status, resp);
		check_word("status after rdata", 32'h0, status);   // reading rdata clears done.
	endtask

	task automatic verify_readback(input logic [7:0] addr);
		logic [31:0] word;
		spi_rsp_t    exp;
		start_frame(addr, 1'b1, 24'h0);
		finish_frame(word);
		exp.addr = addr;
		exp.data = ref_regs[addr];
		check_rsp("reg_rdata", exp, spi_rsp_t'(word));
	endtask

	// outside master owns sclk and din while its select is low.
	task automatic drive_bypass(input int cycles);
		@(posedge clkin);
		spi_ssb_in <= 1'b0;
		repeat (cycles) begin
			@(posedge clkin);
			sclk_in <= next_bit();
			mosi_in <= next_bit();
			adcclk <= next_bit();
			@(negedge clkin);
			compare_pin("sclk", sclk_in, sclk);
			compare_pin("din", mosi_in, din);
		end
		@(posedge clkin);
		spi_ssb_in <= 1'b1;
		sclk_in <= 1'b1;
	endtask

	always @(negedge clkin) begin
		if (arst_n) begin
			if (cs)
				sclk_falls = 0;
			else if (sclk_prev && !sclk)
				sclk_falls++;
			sclk_prev = sclk;
			// the converter owns the data line after the address byte of a read.
			compare_pin("sdio_as_sdo", !cs && frame_rd && sclk_falls > spi_addr_bits,
				sdio_as_sdo);
			compare_pin("miso_out", dout_rdy, miso_out);
			compare_pin("spi_ssb_out", spi_ssb_in & cs, spi_ssb_out);
			compare_pin("adc_clk", adcclk, adc_clk);
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clkin);
		$display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
		$display("Something failed");
		$finish;
	end

	initial begin
		logic [31:0] word;
		logic [1:0]  resp;
		logic [23:0] data;
		logic [23:0] d1;
		lfsr = 32'h3266133f;
		value_errs = 0;
		other_errs = 0;
		sclk_falls = 0;
		sclk_prev = 1'b1;
		frame_rd = 1'b0;
		clkin = 1'b0;
		arst_n = 1'b0;
		aw = '0;
		w = '0;
		ar = '0;
		bready = 1'b0;
		rready = 1'b0;
		adcclk = 1'b0;
		sclk_in = 1'b1;
		mosi_in = 1'b0;
		ss_in = 1'b1;
		spi_ssb_in = 1'b1;
		repeat (5) @(posedge clkin);
		arst_n <= 1'b1;
		@(negedge clkin);
		compare_pin("awready", 1'b0, awready);
		compare_pin("wready", 1'b0, wready);
		compare_pin("arready", 1'b0, arready);
		compare_pin("b.valid", 1'b0, b.valid);
		compare_pin("r.valid", 1'b0, r.valid);
		compare_pin("cs", 1'b1, cs);
		compare_pin("sclk", 1'b1, sclk);

		for (int i = 0; i < num_addr; i++) begin
			addrs[i] = 8'(rand_bits(8)) & 8'hbf;   // bit 6 is the r/w flag on the wire.
			data = 24'(rand_bits(24));
			start_frame(addrs[i], 1'b0, data);
			finish_frame(word);
			ref_regs[addrs[i]] = data;
		end
		for (int i = 0; i < num_addr; i++)
			verify_readback(addrs[i]);

		// a second command while a frame runs is refused.
		d1 = 24'(rand_bits(24));
		start_frame(addrs[1], 1'b0, d1);
		axil_write(reg_wdata, rand_bits(24), resp);
		check_resp("b.resp wdata while busy", resp_okay, resp);
		axil_write(reg_cmd, {24'h0, addrs[0]}, resp);
		check_resp("b.resp cmd while busy", resp_slverr, resp);
		finish_frame(word);
		ref_regs[addrs[1]] = d1;
		axil_write(4'h3, rand_bits(32), resp);
		check_resp("b.resp unmapped", resp_slverr, resp);
		axil_read(4'h6, word, resp);
		check_resp("r.resp unmapped", resp_slverr, resp);
		verify_readback(addrs[0]);
		verify_readback(addrs[1]);

		drive_bypass(64);

		$display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* tb_adc_model.sv */
`timescale 1ns/1ns
module tb_adc_model (
	input  logic cs,
	input  logic sclk,
	input  logic din,
	output logic dout_rdy
);
	logic [23:0] reg_file [256];
	logic [7:0]  comm;       // communications byte of the frame.
	logic [23:0] data_in;
	logic [23:0] data_out;
	logic        out_bit;
	int          nbits;      // bits clocked in since cs fell.

	// bit 6 of the byte is the r/w flag, so it is not part of the index.
	function automatic logic [7:0] reg_index(input logic [7:0] c);
		return {c[7], 1'b0, c[5:0]};
	endfunction

	initial begin
		for (int i = 0; i < 256; i++)
			reg_file[i] = {8'(i), ~8'(i), 8'(i) ^ 8'h5a};
		out_bit = 1'b1;
		nbits = 0;
	end

	assign dout_rdy = cs ? 1'b1 : out_bit;   // line idles high.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// din is taken on rising sclk
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always @(posedge sclk or posedge cs) begin
		if (cs === 1'b1) begin
			nbits = 0;
		end else if (cs === 1'b0) begin
			if (nbits < 8)
				comm = {comm[6:0], din};
			else
				data_in = {data_in[22:0], din};
			nbits = nbits + 1;
			if (nbits == 32 && !comm[6])
				reg_file[reg_index(comm)] = data_in;   // write lands at the last bit.
		end
	end

	// read data leaves on falling sclk, msb first.
	always @(negedge sclk) begin
		if (cs === 1'b0) begin
			if (nbits == 8 && comm[6])
				data_out = reg_file[reg_index(comm)];
			out_bit = (nbits >= 8 && comm[6]) ? data_out[23] : 1'b1;
			data_out = data_out << 1;
		end
	end

endmodule

/* ad7794_top.sv */
`timescale 1ns/1ns
module ad7794_top #(
	parameter int                    TSCKHALF = 4,
	parameter ad7794_pkg::spi_mode_t SPIMODE = ad7794_pkg::mode_chain
) (
	input  logic               clkin,
	input  logic               arst_n,
	input  axil_pkg::axil_aw_t aw,
	output logic               awready,
	input  axil_pkg::axil_w_t  w,
	output logic               wready,
	output axil_pkg::axil_b_t  b,
	input  logic               bready,
	input  axil_pkg::axil_ar_t ar,
	output logic               arready,
	output axil_pkg::axil_r_t  r,
	input  logic               rready,
	output logic               sdio_as_sdo,
	output logic               adc_clk,
	output logic               cs,
	output logic               sclk,
	output logic               din,
	input  logic               dout_rdy,
	input  logic               adcclk,
	input  logic               sclk_in,
	input  logic               mosi_in,
	input  logic               ss_in,
	output logic               miso_out,
	input  logic               spi_ssb_in,
	output logic               spi_ssb_out
);
	import ad7794_pkg::*;

	// command path between the register block and the converter port.
	logic     start, busy, ready;
	spi_cmd_t cmd;
	spi_rsp_t rsp;

	ad7794_regs regs (
		.clkin(clkin), .arst_n(arst_n),
		.aw(aw), .awready(awready), .w(w), .wready(wready), .b(b), .bready(bready),
		.ar(ar), .arready(arready), .r(r), .rready(rready),
		.start(start), .cmd(cmd), .busy(busy), .ready(ready), .rsp(rsp)
	);

	ad7794 #(.TSCKHALF(TSCKHALF), .SPIMODE(SPIMODE)) adc (
		.clkin(clkin), .arst_n(arst_n), .start(start), .cmd(cmd),
		.busy(busy), .ready(ready), .rsp(rsp), .sdio_as_sdo(sdio_as_sdo),
		.adc_clk(adc_clk), .cs(cs), .sclk(sclk), .din(din), .dout_rdy(dout_rdy),
		.adcclk(adcclk), .sclk_in(sclk_in), .mosi_in(mosi_in), .ss_in(ss_in),
		.miso_out(miso_out), .spi_ssb_in(spi_ssb_in), .spi_ssb_out(spi_ssb_out)
	);

endmodule

/* ad7794_regs.sv */
`timescale 1ns/1ns
module ad7794_regs (
	input  logic                 clkin,
	input  logic                 arst_n,
	input  axil_pkg::axil_aw_t   aw,
	output logic                 awready,
	input  axil_pkg::axil_w_t    w,
	output logic                 wready,
	output axil_pkg::axil_b_t    b,
	input  logic                 bready,
	input  axil_pkg::axil_ar_t   ar,
	output logic                 arready,
	output axil_pkg::axil_r_t    r,
	input  logic                 rready,
	output logic                 start,
	output ad7794_pkg::spi_cmd_t cmd,
	input  logic                 busy,
	input  logic                 ready,
	input  ad7794_pkg::spi_rsp_t rsp
);
	import axil_pkg::*;
	import ad7794_pkg::*;

	logic                      wr_hs, rd_hs;
	logic                      busy_any;     // frame requested or running.
	logic                      b_valid, r_valid;
	logic [1:0]                b_resp, r_resp;
	logic [axil_data_bits-1:0] r_data, rd_word;
	logic                      rd_err;
	logic [spi_data_bits-1:0]  wdata;
	logic                      done;
	spi_rsp_t                  result;

	assign wr_hs = awready & aw.valid & w.valid;  // wready moves with awready.
	assign rd_hs = arready & ar.valid;
	assign busy_any = busy | start;
	assign b = '{resp: b_resp, valid: b_valid};
	assign r = '{data: r_data, resp: r_resp, valid: r_valid};

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// write channel
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			b_valid <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= 1'b0;
			awready <= aw.valid & w.valid & ~b_valid & ~awready;
			wready <= aw.valid & w.valid & ~b_valid & ~awready;
			if (wr_hs) begin
				b_valid <= 1'b1;
				if (aw.addr == reg_cmd && !busy_any)
					start <= 1'b1;
			end else if (bready) begin
				b_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clkin) begin
		if (wr_hs) begin
			b_resp <= resp_okay;
			case (aw.addr)
				reg_cmd: begin
					if (busy_any) begin
						b_resp <= resp_slverr;   // one frame at a time.
					end else begin
						cmd.addr <= w.data[spi_addr_bits-1:0];
						cmd.rd <= w.data[spi_addr_bits];
						cmd.data <= wdata;
					end
				end
				reg_wdata: wdata <= w.data[spi_data_bits-1:0];
				reg_status, reg_rdata: ;     // read only, write ignored.
				default: b_resp <= resp_slverr;
			endcase
		end
		if (ready)
			result <= rsp;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// read channel
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		rd_word = '0;
		rd_err = 1'b0;
		case (ar.addr)
			reg_cmd: rd_word = '0;           // write-only.
			reg_wdata: rd_word = {{(axil_data_bits - spi_data_bits){1'b0}}, wdata};
			reg_status: rd_word = {30'd0, done, busy_any};
			reg_rdata: rd_word = {result.addr, result.data};
			default: rd_err = 1'b1;
		endcase
	end

	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			r_valid <= 1'b0;
			done <= 1'b0;
		end else begin
			arready <= ar.valid & ~r_valid & ~arready;
			if (rd_hs)
				r_valid <= 1'b1;
			else if (rready)
				r_valid <= 1'b0;
			if (ready)
				done <= 1'b1;                // sticky until the result is read.
			else if (rd_hs && ar.addr == reg_rdata)
				done <= 1'b0;
		end
	end

	always_ff @(posedge clkin) begin
		if (rd_hs) begin
			r_data <= rd_word;
			r_resp <= rd_err ? resp_slverr : resp_okay;
		end
	end

endmodule

/* ad7794.sv */
`timescale 1ns/1ns
module ad7794 #(
	parameter int                    TSCKHALF = 4,
	parameter ad7794_pkg::spi_mode_t SPIMODE = ad7794_pkg::mode_chain
) (
	input  logic                 clkin,
	input  logic                 arst_n,
	input  logic                 start,
	input  ad7794_pkg::spi_cmd_t cmd,
	output logic                 busy,
	output logic                 ready,
	output ad7794_pkg::spi_rsp_t rsp,
	output logic                 sdio_as_sdo,
	output logic                 adc_clk,
	output logic                 cs,
	output logic                 sclk,
	output logic                 din,
	input  logic                 dout_rdy,
	input  logic                 adcclk,
	input  logic                 sclk_in,
	input  logic                 mosi_in,
	input  logic                 ss_in,
	output logic                 miso_out,
	input  logic                 spi_ssb_in,
	output logic                 spi_ssb_out
);
	import ad7794_pkg::*;

	logic cs_m, sck_m, sdi_m;   // internal master pins.

	spi_master #(.TSCKHALF(TSCKHALF)) ad7794_spi (
		.clkin(clkin), .arst_n(arst_n), .start(start), .cmd(cmd),
		.busy(busy), .ready(ready), .rsp(rsp),
		.cs(cs_m), .sck(sck_m), .sdi(sdi_m), .sdo(dout_rdy),
		.sdio_as_sdo(sdio_as_sdo)
	);

	generate
		if (SPIMODE == mode_passthrough) begin : g_passthrough
			assign sclk = sclk_in;
			assign din = mosi_in;
			assign cs = ss_in;
		end else if (SPIMODE == mode_chain) begin : g_chain
			// outside master gets sclk and din while its select is low.
			assign sclk = spi_ssb_in ? sck_m : sclk_in;
			assign din = spi_ssb_in ? sdi_m : mosi_in;
			assign cs = cs_m;
		end else begin : g_standalone
			assign sclk = sck_m;
			assign din = sdi_m;
			assign cs = cs_m;
		end
	endgenerate

	assign adc_clk = adcclk;               // master clock straight through.
	assign miso_out = dout_rdy;            // outside master always sees the converter.
	assign spi_ssb_out = spi_ssb_in & cs;

endmodule

/* spi_master.sv */
`timescale 1ns/1ns
module spi_master #(
	parameter int TSCKHALF = 4
) (
	input  logic                 clkin,
	input  logic                 arst_n,
	input  logic                 start,
	input  ad7794_pkg::spi_cmd_t cmd,
	output logic                 busy,
	output logic                 ready,
	output ad7794_pkg::spi_rsp_t rsp,
	output logic                 cs,
	output logic                 sck,
	output logic                 sdi,
	input  logic                 sdo,
	output logic                 sdio_as_sdo
);
	import ad7794_pkg::*;

	localparam int cnt_w = $clog2(TSCKHALF + 1);
	localparam int last_half = spi_half_periods - 1;

	logic [cnt_w-1:0]          cnt;        // clkin cycles inside a half period.
	logic [6:0]                half;       // half period index of the frame.
	logic [6:0]                half_nxt;
	logic                      half_end;
	logic                      edge_next;  // an sck edge starts the next half period.
	spi_cmd_t                  cmd_q;
	logic [spi_frame_bits-1:0] sreg;
	logic [spi_data_bits-1:0]  rx;
	logic [spi_addr_bits-1:0]  addr_byte;

	assign half_end = (cnt == cnt_w'(TSCKHALF - 1));
	assign half_nxt = half + 7'd1;
	assign edge_next = busy & half_end & (half_nxt < 7'(last_half));
	assign sdi = sreg[spi_frame_bits-1];
	// converter drives the shared line once the address byte is out.
	assign sdio_as_sdo = busy & cmd_q.rd & (half > 7'(2 * spi_addr_bits));

	// the converter wants the read flag in bit 6 of the communications byte.
	always_comb begin
		addr_byte = cmd.addr;
		addr_byte[spi_rd_bit] = cmd.rd;
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// frame sequencing
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clkin or negedge arst_n) begin
		if (!arst_n) begin
			busy <= 1'b0;
			ready <= 1'b0;
			cs <= 1'b1;
			sck <= 1'b1;             // sck idles high.
			cnt <= '0;
			half <= '0;
		end else begin
			ready <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					cs <= 1'b0;      // half 0 is the cs setup time.
					cnt <= '0;
					half <= '0;
				end
			end else if (!half_end) begin
				cnt <= cnt + 1'b1;
			end else begin
				cnt <= '0;
				if (half == 7'(last_half)) begin
					busy <= 1'b0;    // hold time done, release the converter.
					cs <= 1'b1;
					ready <= 1'b1;
				end else begin
					half <= half_nxt;
					if (half_nxt < 7'(last_half))
						sck <= ~half_nxt[0];  // odd halves low, even halves high.
				end
			end
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// shift path
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clkin) begin
		if (!busy && start) begin
			cmd_q <= cmd;
			sreg <= {addr_byte, cmd.rd ? {spi_data_bits{1'b0}} : cmd.data};
			rx <= '0;
		end else if (edge_next) begin
			// first bit is already on sdi since cs fell.
			if (half_nxt[0] && half_nxt > 7'd1)
				sreg <= {sreg[spi_frame_bits-2:0], 1'b0};
			if (!half_nxt[0] && cmd_q.rd)
				rx <= {rx[spi_data_bits-2:0], sdo};   // sample on rising sck.
		end
		if (busy && half_end && half == 7'(last_half)) begin
			rsp.addr <= cmd_q.addr;
			rsp.data <= cmd_q.rd ? rx : cmd_q.data;  // a write echoes its data.
		end
	end

endmodule

/* axil_pkg.sv */
package axil_pkg;

	localparam int axil_addr_bits = 4;
	localparam int axil_data_bits = 32;

	localparam logic [1:0] resp_okay = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register map
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam logic [axil_addr_bits-1:0] reg_cmd = 4'h0;    // addr in 7..0, read in 8.
	localparam logic [axil_addr_bits-1:0] reg_wdata = 4'h4;  // data word in 23..0.
	localparam logic [axil_addr_bits-1:0] reg_status = 4'h8; // busy in 0, done in 1.
	localparam logic [axil_addr_bits-1:0] reg_rdata = 4'hc;  // addr in 31..24, data below.

	// channel payloads, ready travels back as a plain bit.
	typedef struct packed {
		logic [axil_addr_bits-1:0] addr;
		logic                      valid;
	} axil_aw_t;

	typedef struct packed {
		logic [axil_data_bits-1:0] data;
		logic                      valid;
	} axil_w_t;

	typedef struct packed {
		logic [1:0] resp;
		logic       valid;
	} axil_b_t;

	typedef struct packed {
		logic [axil_addr_bits-1:0] addr;
		logic                      valid;
	} axil_ar_t;

	typedef struct packed {
		logic [axil_data_bits-1:0] data;
		logic [1:0]                resp;
		logic                      valid;
	} axil_r_t;

endpackage

/* ad7794_pkg.sv */
package ad7794_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// serial frame of the converter
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int spi_addr_bits = 8;     // communications byte.
	localparam int spi_data_bits = 24;    // data field.
	localparam int spi_frame_bits = spi_addr_bits + spi_data_bits;
	// one half period of setup, 32 sck periods, one half period of hold.
	localparam int spi_half_periods = 2 * spi_frame_bits + 2;
	localparam int spi_rd_bit = 6;        // r/w bit inside the communications byte.

	// command from the register block to the master.
	typedef struct packed {
		logic [spi_addr_bits-1:0] addr;
		logic                     rd;
		logic [spi_data_bits-1:0] data;
	} spi_cmd_t;

	// result of a finished frame.
	typedef struct packed {
		logic [spi_addr_bits-1:0] addr;   // address of the frame.
		logic [spi_data_bits-1:0] data;
	} spi_rsp_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pin routing modes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef string spi_mode_t;

	localparam spi_mode_t mode_standalone = "standalone";   // internal master only.
	localparam spi_mode_t mode_chain = "chain";             // shared with outside master.
	localparam spi_mode_t mode_passthrough = "passthrough"; // outside master only.

endpackage
